/* hawk_cfg_pkg.sv */
/*
 * Sizes of the host page space, the DRAM page space and the att.
 * Imported by every RTL block and by the testbench for port widths.
 */
package hawk_cfg_pkg;

    ////////////////////////////////////////
    // page spaces
    ////////////////////////////////////////

    // host physical page number width
    localparam int HPPA_W = 4;

    // dram page number width
    localparam int DPAGE_W = 4;

    // att entries and free list slots, one per host page
    localparam int NUM_PAGES = 2 ** HPPA_W;

endpackage

/* hawk_ctrl_pkg.sv */
/*
 * State encodings of the control unit, the page read manager
 * and the page writer.
 */
package hawk_ctrl_pkg;

    // control unit, arbitration and grant sequencing
    typedef enum logic [3:0] {
        IDLE,
        CHK_RD_ACTIVE,
        CHK_WR_ACTIVE,
        RD_LOOKUP_ALLOCATE,
        WR_LOOKUP_ALLOCATE,
        RD_TBL_UPDATE,
        WR_TBL_UPDATE
    } ctrl_state_e;

    // page read manager
    typedef enum logic [1:0] {
        PGRD_IDLE,
        PGRD_LOOKUP,
        PGRD_WAIT
    } pgrd_state_e;

    // page writer, init runs once after reset
    typedef enum logic [1:0] {PGWR_INIT_ATT, PGWR_INIT_LIST, PGWR_RUN} pgwr_state_e;

endpackage

/* hawk_ctrl_unit.sv */
/*
 * Control unit. Holds the init levels until the page writer is done,
 * then serves one CPU read or write at a time, alternating when both
 * are pending, and pulses the grant once the lookup or update is over.
 */
`timescale 1ns/1ps

module hawk_ctrl_unit (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            cpu_rd_valid,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0] cpu_rd_hppa,
    input  logic                            cpu_wr_valid,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0] cpu_wr_hppa,
    input  logic                            init_att_done,
    input  logic                            init_list_done,
    input  logic                            pgrd_mngr_ready,
    input  logic                            allow_cpu_access,
    input  logic                            tbl_update,
    input  logic                            tbl_update_done,
    output logic                            init_att,
    output logic                            init_list,
    output logic                            lkup_req,
    output logic [hawk_cfg_pkg::HPPA_W-1:0] lkup_hppa,
    output logic                            cpu_rd_grant,
    output logic                            cpu_wr_grant
);
    import hawk_cfg_pkg::*;
    import hawk_ctrl_pkg::*;

    ctrl_state_e       state_q, state_d;
    logic              init_att_d, init_list_d;
    logic              lkup_req_d;
    logic [HPPA_W-1:0] lkup_hppa_d;
    logic              rd_grant_d, wr_grant_d;
    logic              lkup_ok;

    // no new lookup in a grant cycle, the cpu still holds that valid
    assign lkup_ok = pgrd_mngr_ready && !cpu_rd_grant && !cpu_wr_grant;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////
    always_comb begin
        state_d     = state_q;
        init_att_d  = init_att;
        init_list_d = init_list;
        lkup_req_d  = 1'b0;
        lkup_hppa_d = lkup_hppa;
        rd_grant_d  = 1'b0;
        wr_grant_d  = 1'b0;
        case (state_q)
            IDLE: begin
                // drop each init level after its done pulse
                if (init_att_done) begin
                    init_att_d = 1'b0;
                end
                if (init_list_done) begin
                    init_list_d = 1'b0;
                    state_d     = CHK_RD_ACTIVE;
                end
            end
            // reads preferred, writes as fallback
            CHK_RD_ACTIVE: begin
                if (lkup_ok && cpu_rd_valid) begin
                    lkup_req_d  = 1'b1;
                    lkup_hppa_d = cpu_rd_hppa;
                    state_d     = RD_LOOKUP_ALLOCATE;
                end else if (lkup_ok && cpu_wr_valid) begin
                    lkup_req_d  = 1'b1;
                    lkup_hppa_d = cpu_wr_hppa;
                    state_d     = WR_LOOKUP_ALLOCATE;
                end
            end
            // writes preferred, reads as fallback
            CHK_WR_ACTIVE: begin
                if (lkup_ok && cpu_wr_valid) begin
                    lkup_req_d  = 1'b1;
                    lkup_hppa_d = cpu_wr_hppa;
                    state_d     = WR_LOOKUP_ALLOCATE;
                end else if (lkup_ok && cpu_rd_valid) begin
                    lkup_req_d  = 1'b1;
                    lkup_hppa_d = cpu_rd_hppa;
                    state_d     = RD_LOOKUP_ALLOCATE;
                end
            end
            // hit grants at once, miss waits for the writer
            RD_LOOKUP_ALLOCATE: begin
                if (allow_cpu_access) begin
                    rd_grant_d = 1'b1;
                    state_d    = CHK_WR_ACTIVE;
                end else if (tbl_update) begin
                    state_d = RD_TBL_UPDATE;
                end
            end
            WR_LOOKUP_ALLOCATE: begin
                if (allow_cpu_access) begin
                    wr_grant_d = 1'b1;
                    state_d    = CHK_RD_ACTIVE;
                end else if (tbl_update) begin
                    state_d = WR_TBL_UPDATE;
                end
            end
            RD_TBL_UPDATE: begin
                if (tbl_update_done) begin
                    rd_grant_d = 1'b1;
                    state_d    = CHK_WR_ACTIVE;
                end
            end
            WR_TBL_UPDATE: begin
                if (tbl_update_done) begin
                    wr_grant_d = 1'b1;
                    state_d    = CHK_RD_ACTIVE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            // both init phases requested out of reset
            init_att     <= 1'b1;
            init_list    <= 1'b1;
            lkup_req     <= 1'b0;
            cpu_rd_grant <= 1'b0;
            cpu_wr_grant <= 1'b0;
        end else begin
            state_q      <= state_d;
            init_att     <= init_att_d;
            init_list    <= init_list_d;
            lkup_req     <= lkup_req_d;
            cpu_rd_grant <= rd_grant_d;
            cpu_wr_grant <= wr_grant_d;
        end
    end

    // lookup page, only meaningful with lkup_req
    always_ff @(posedge clk_i) begin
        lkup_hppa <= lkup_hppa_d;
    end

    // one request in flight, so never two grants at once
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(cpu_rd_grant && cpu_wr_grant))
        else $error("read and write grant high together");

    // lookup only launched while the manager was ready
    a_lkup_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(lkup_req) |-> $past(pgrd_mngr_ready))
        else $error("lkup_req raised while manager busy");

endmodule

/* hawk_pgrd_manager.sv */
/*
 * Page read manager. Latches a lookup, reads the att a cycle later and
 * answers with a hit strobe, or with a table update that maps the page
 * to the free list head. Drives the DRAM page for the grant.
 */
`timescale 1ns/1ps

module hawk_pgrd_manager (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             lkup_req,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0]  lkup_hppa,
    input  logic                             att_rd_hit,
    input  logic [hawk_cfg_pkg::DPAGE_W-1:0] att_rd_dpage,
    input  logic [hawk_cfg_pkg::DPAGE_W-1:0] free_dpage,
    output logic                             pgrd_mngr_ready,
    output logic [hawk_cfg_pkg::HPPA_W-1:0]  att_rd_hppa,
    output logic                             allow_cpu_access,
    output logic                             tbl_update,
    output logic [hawk_cfg_pkg::HPPA_W-1:0]  upd_hppa,
    output logic [hawk_cfg_pkg::DPAGE_W-1:0] upd_dpage,
    output logic [hawk_cfg_pkg::DPAGE_W-1:0] grant_dpage
);
    import hawk_cfg_pkg::*;
    import hawk_ctrl_pkg::*;

    pgrd_state_e       state_q;
    logic [HPPA_W-1:0] hppa_q;

    // busy from the lkup_req cycle until back in idle
    assign pgrd_mngr_ready = (state_q == PGRD_IDLE) && !lkup_req;

    // att read port follows the latched page
    assign att_rd_hppa = hppa_q;

    ////////////////////////////////////////
    // fsm and answer strobes
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q          <= PGRD_IDLE;
            allow_cpu_access <= 1'b0;
            tbl_update       <= 1'b0;
        end else begin
            allow_cpu_access <= 1'b0;
            tbl_update       <= 1'b0;
            case (state_q)
                PGRD_IDLE: begin
                    if (lkup_req) begin
                        state_q <= PGRD_LOOKUP;
                    end
                end
                PGRD_LOOKUP: begin
                    if (att_rd_hit) begin
                        allow_cpu_access <= 1'b1;
                        state_q          <= PGRD_IDLE;
                    end else begin
                        // miss, writer maps the page this cycle
                        tbl_update <= 1'b1;
                        state_q    <= PGRD_WAIT;
                    end
                end
                // table write lands here
                PGRD_WAIT: state_q <= PGRD_IDLE;
                default:   state_q <= PGRD_IDLE;
            endcase
        end
    end

    // page numbers, held until the next lookup
    always_ff @(posedge clk_i) begin
        if (state_q == PGRD_IDLE && lkup_req) begin
            hppa_q <= lkup_hppa;
        end
        if (state_q == PGRD_LOOKUP) begin
            if (att_rd_hit) begin
                grant_dpage <= att_rd_dpage;
            end else begin
                // new mapping from the free list head
                grant_dpage <= free_dpage;
                upd_dpage   <= free_dpage;
                upd_hppa    <= hppa_q;
            end
        end
    end

endmodule

/* hawk_pg_writer.sv */
/*
 * Page writer. Owns the att and the free list. After reset it clears
 * every att entry, then fills the free list with all DRAM pages, and
 * from then on writes one entry and pops the list per table update.
 */
`timescale 1ns/1ps

module hawk_pg_writer (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             init_att,
    input  logic                             init_list,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0]  att_rd_hppa,
    input  logic                             tbl_update,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0]  upd_hppa,
    input  logic [hawk_cfg_pkg::DPAGE_W-1:0] upd_dpage,
    output logic                             init_att_done,
    output logic                             init_list_done,
    output logic                             att_rd_hit,
    output logic [hawk_cfg_pkg::DPAGE_W-1:0] att_rd_dpage,
    output logic [hawk_cfg_pkg::DPAGE_W-1:0] free_dpage,
    output logic                             tbl_update_done
);
    import hawk_cfg_pkg::*;
    import hawk_ctrl_pkg::*;

    pgwr_state_e        state_q;
    logic [HPPA_W-1:0]  init_cnt;
    // att entries, valid bit and mapped dram page
    logic               att_valid [NUM_PAGES];
    logic [DPAGE_W-1:0] att_dpage [NUM_PAGES];
    // free list fifo
    logic [DPAGE_W-1:0] free_mem  [NUM_PAGES];
    logic [HPPA_W-1:0]  rd_ptr, wr_ptr;
    logic [HPPA_W:0]    free_cnt;
    logic               cnt_last, att_clr, list_push, list_pop;

    assign cnt_last  = (init_cnt == HPPA_W'(NUM_PAGES - 1));
    assign att_clr   = (state_q == PGWR_INIT_ATT) && init_att;
    assign list_push = (state_q == PGWR_INIT_LIST) && init_list;
    assign list_pop  = (state_q == PGWR_RUN) && tbl_update;

    // combinational read ports
    assign att_rd_hit   = att_valid[att_rd_hppa];
    assign att_rd_dpage = att_dpage[att_rd_hppa];
    assign free_dpage   = free_mem[rd_ptr];

    ////////////////////////////////////////
    // init sequencing and list pointers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q         <= PGWR_INIT_ATT;
            init_cnt        <= '0;
            rd_ptr          <= '0;
            wr_ptr          <= '0;
            free_cnt        <= '0;
            init_att_done   <= 1'b0;
            init_list_done  <= 1'b0;
            tbl_update_done <= 1'b0;
        end else begin
            init_att_done   <= att_clr && cnt_last;
            init_list_done  <= list_push && cnt_last;
            tbl_update_done <= list_pop;
            // counter wraps to 0 between the two phases
            if (att_clr || list_push) begin
                init_cnt <= init_cnt + 1'b1;
            end
            if (att_clr && cnt_last) begin
                state_q <= PGWR_INIT_LIST;
            end
            if (list_push && cnt_last) begin
                state_q <= PGWR_RUN;
            end
            if (list_push) begin
                wr_ptr   <= wr_ptr + 1'b1;
                free_cnt <= free_cnt + 1'b1;
            end else if (list_pop) begin
                rd_ptr   <= rd_ptr + 1'b1;
                free_cnt <= free_cnt - 1'b1;
            end
        end
    end

    // storage writes
    always_ff @(posedge clk_i) begin
        if (att_clr) begin
            att_valid[init_cnt] <= 1'b0;
        end else if (list_pop) begin
            att_valid[upd_hppa] <= 1'b1;
            att_dpage[upd_hppa] <= upd_dpage;
        end
        // pages pushed in order 0 .. NUM_PAGES-1
        if (list_push) begin
            free_mem[wr_ptr] <= DPAGE_W'(init_cnt);
        end
    end

    // one dram page per host page, so the list never runs dry
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tbl_update |-> free_cnt != '0)
        else $error("free list pop while empty");

    a_no_upd_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tbl_update |-> !init_att && !init_list && state_q == PGWR_RUN)
        else $error("table update during init");

endmodule

/* hawk_top.sv */
/*
 * Top level of the access control slice. Ties the control unit, page
 * read manager and page writer to the CPU request and grant ports.
 */
`timescale 1ns/1ps

module hawk_top (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             cpu_rd_valid,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0]  cpu_rd_hppa,
    input  logic                             cpu_wr_valid,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0]  cpu_wr_hppa,
    output logic                             cpu_rd_grant,
    output logic                             cpu_wr_grant,
    output logic [hawk_cfg_pkg::DPAGE_W-1:0] grant_dpage
);
    import hawk_cfg_pkg::*;

    // ctrl unit <-> page writer
    logic init_att, init_list, init_att_done, init_list_done, tbl_update_done;
    // ctrl unit <-> page read manager
    logic              lkup_req, pgrd_mngr_ready, allow_cpu_access, tbl_update;
    logic [HPPA_W-1:0] lkup_hppa;
    // page read manager <-> page writer
    logic [HPPA_W-1:0]  att_rd_hppa, upd_hppa;
    logic               att_rd_hit;
    logic [DPAGE_W-1:0] att_rd_dpage, free_dpage, upd_dpage;

    hawk_ctrl_unit u_ctrl (
        .clk_i, .rst_ni,
        .cpu_rd_valid, .cpu_rd_hppa, .cpu_wr_valid, .cpu_wr_hppa,
        .init_att_done, .init_list_done, .pgrd_mngr_ready,
        .allow_cpu_access, .tbl_update, .tbl_update_done,
        .init_att, .init_list, .lkup_req, .lkup_hppa,
        .cpu_rd_grant, .cpu_wr_grant
    );

    hawk_pgrd_manager u_pgrd (
        .clk_i, .rst_ni,
        .lkup_req, .lkup_hppa, .att_rd_hit, .att_rd_dpage, .free_dpage,
        .pgrd_mngr_ready, .att_rd_hppa, .allow_cpu_access, .tbl_update,
        .upd_hppa, .upd_dpage, .grant_dpage
    );

    hawk_pg_writer u_pgwr (
        .clk_i, .rst_ni,
        .init_att, .init_list, .att_rd_hppa, .tbl_update, .upd_hppa, .upd_dpage,
        .init_att_done, .init_list_done, .att_rd_hit, .att_rd_dpage,
        .free_dpage, .tbl_update_done
    );

endmodule

/* hawk_checker.sv */
/*
 * Scoreboard for the access control slice. Watches the CPU ports,
 * keeps a reference page map and counts every grant mismatch.
 */
`timescale 1ns/1ps

module hawk_checker (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             cpu_rd_valid,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0]  cpu_rd_hppa,
    input  logic                             cpu_wr_valid,
    input  logic [hawk_cfg_pkg::HPPA_W-1:0]  cpu_wr_hppa,
    input  logic                             cpu_rd_grant,
    input  logic                             cpu_wr_grant,
    input  logic [hawk_cfg_pkg::DPAGE_W-1:0] grant_dpage,
    output int                               err_cnt,
    output int                               rd_grant_cnt,
    output int                               wr_grant_cnt
);
    import hawk_cfg_pkg::*;

    // reference map, -1 while a host page is untouched
    int page_map [NUM_PAGES];
    int next_page;
    int cycles;
    // request already granted, cleared once its valid drops
    bit rd_done, wr_done;
    // kind the next grant must have after a contended grant
    bit order_set, order_wr;

    task automatic report_error(input string msg);
        err_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic check_grant(input bit wr, input logic [HPPA_W-1:0] hppa);
        string kind;
        bit    pending;
        int    exp_page;
        kind    = wr ? "write" : "read";
        pending = wr ? (cpu_wr_valid && !wr_done) : (cpu_rd_valid && !rd_done);
        if (cycles < 2 * NUM_PAGES)
            report_error($sformatf("%s grant %0d cycles after reset", kind, cycles));
        if (!pending)
            report_error($sformatf("%s grant with no pending request", kind));
        if (order_set && order_wr != wr)
            report_error($sformatf("%s grant, expected the other kind", kind));
        // both kinds waiting, next grant flips
        order_set = cpu_rd_valid && !rd_done && cpu_wr_valid && !wr_done;
        order_wr  = !wr;
        // first touch takes the next dram page
        if (page_map[hppa] < 0) begin
            page_map[hppa] = next_page;
            next_page++;
        end
        exp_page = page_map[hppa];
        if (grant_dpage !== DPAGE_W'(exp_page))
            report_error($sformatf("%s hppa %0d got dpage %0d, expected %0d",
                                   kind, hppa, grant_dpage, exp_page));
        if (wr) begin
            wr_done = 1'b1;
            wr_grant_cnt++;
        end else begin
            rd_done = 1'b1;
            rd_grant_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // sampling at the falling edge
    ////////////////////////////////////////
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            foreach (page_map[i]) page_map[i] = -1;
            next_page    = 0;
            cycles       = 0;
            err_cnt      = 0;
            rd_grant_cnt = 0;
            wr_grant_cnt = 0;
            rd_done      = 1'b0;
            wr_done      = 1'b0;
            order_set    = 1'b0;
            order_wr     = 1'b0;
        end else begin
            cycles++;
            if (cpu_rd_grant && cpu_wr_grant)
                report_error("read and write grant in the same cycle");
            if (cpu_rd_grant) check_grant(1'b0, cpu_rd_hppa);
            if (cpu_wr_grant) check_grant(1'b1, cpu_wr_hppa);
            // a dropped valid ends the request
            if (!cpu_rd_valid) rd_done = 1'b0;
            if (!cpu_wr_valid) wr_done = 1'b0;
        end
    end

endmodule

/* tb_hawk_top.sv */
/*
 * Testbench for the access control slice. Drives random CPU read and
 * write requests from a fixed seed and leaves the comparing to the
 * checker, then reports the closing counts.
 */
`timescale 1ns/1ps

module tb_hawk_top;
    import hawk_cfg_pkg::*;

    logic               clk_i, rst_ni;
    logic               cpu_rd_valid, cpu_wr_valid;
    logic [HPPA_W-1:0]  cpu_rd_hppa, cpu_wr_hppa;
    logic               cpu_rd_grant, cpu_wr_grant;
    logic [DPAGE_W-1:0] grant_dpage;
    int                 err_cnt, rd_grant_cnt, wr_grant_cnt;
    int                 timeouts, fails;

    hawk_top UUT (
        .clk_i, .rst_ni,
        .cpu_rd_valid, .cpu_rd_hppa, .cpu_wr_valid, .cpu_wr_hppa,
        .cpu_rd_grant, .cpu_wr_grant, .grant_dpage
    );

    hawk_checker u_checker (
        .clk_i, .rst_ni,
        .cpu_rd_valid, .cpu_rd_hppa, .cpu_wr_valid, .cpu_wr_hppa,
        .cpu_rd_grant, .cpu_wr_grant, .grant_dpage,
        .err_cnt, .rd_grant_cnt, .wr_grant_cnt
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////
    // request side helpers
    ////////////////////////////////////////
    task automatic raise_request(input bit wr);
        logic [HPPA_W-1:0] hppa;
        hppa = HPPA_W'($urandom_range(NUM_PAGES - 1, 0));
        if (wr) begin
            cpu_wr_valid = 1'b1;
            cpu_wr_hppa  = hppa;
        end else begin
            cpu_rd_valid = 1'b1;
            cpu_rd_hppa  = hppa;
        end
    endtask

    // grants are registered, so look just after the edge
    task automatic wait_grant(input bit wr);
        int waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            #1;
            waited++;
        end while (!(wr ? cpu_wr_grant : cpu_rd_grant) && waited < 100);
        if (!(wr ? cpu_wr_grant : cpu_rd_grant)) begin
            timeouts++;
            $display("timeout: no %s grant within 100 cycles at %0t",
                     wr ? "write" : "read", $time);
        end
    endtask

    // first request is already pending from reset
    task automatic serve_side(input bit wr, input int count);
        for (int n = 0; n < count && timeouts == 0; n++) begin
            if (n != 0) begin
                // idle gap, at least one cycle with valid low
                do begin
                    @(posedge clk_i);
                    #1;
                end while ($urandom_range(2, 0) == 0);
                raise_request(wr);
            end
            wait_grant(wr);
            // valid held through the grant cycle, dropped after it
            @(posedge clk_i);
            #1;
            if (wr) cpu_wr_valid = 1'b0;
            else cpu_rd_valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(18427));
        clk_i    = 1'b0;
        rst_ni   = 1'b0;
        timeouts = 0;
        // both kinds pending while init still runs
        raise_request(1'b0);
        raise_request(1'b1);
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // 200 reads and 200 writes
        fork
            serve_side(1'b0, 200);
            serve_side(1'b1, 200);
        join
        repeat (4) @(posedge clk_i);
        fails = err_cnt + timeouts;
        if (rd_grant_cnt + wr_grant_cnt != 400) begin
            $display("grant count wrong: %0d grants seen for 400 requests",
                     rd_grant_cnt + wr_grant_cnt);
            fails++;
        end
        $display("errors: %0d, timeouts: %0d, grants: %0d read %0d write",
                 err_cnt, timeouts, rd_grant_cnt, wr_grant_cnt);
        if (fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* hawk_top.f */
hawk_cfg_pkg.sv
hawk_ctrl_pkg.sv
hawk_ctrl_unit.sv
hawk_pgrd_manager.sv
hawk_pg_writer.sv
hawk_top.sv
hawk_checker.sv
tb_hawk_top.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_hawk_top
FILELIST = hawk_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
